// ==== kicker_defines.svh ====
`ifndef KICKER_DEFINES_SVH
`define KICKER_DEFINES_SVH

// SDRAM byte map of the downloaded image
// Main CPU ROM sits at the bottom of the image
`define SCR_START   25'h000040
`define OBJ_START   25'h000080

// PROM bytes go to the PROM strobe and never reach SDRAM
`define PROM_START  25'h0000C0

// Pixel clock ratio, CEN_N pulses every CEN_M clk cycles
`define CEN_N       16
`define CEN_M       125

// Reads the SDRAM controller accepts after reset
`define SDRAM_CREDITS 2

`endif

// ==== kicker_pkg.sv ====
package kicker_pkg;

    // Read slot tags, also the arbiter priority order
    typedef enum logic [1:0] {
        SLOT_SCR  = 2'd0,
        SLOT_OBJ  = 2'd1,
        SLOT_MAIN = 2'd2
    } slot_id_e;

    // One SDRAM programming write
    typedef struct packed {
        logic [21:0] addr;  // Word address
        logic [7:0]  data;
        logic [1:0]  mask;  // Active low byte enables
    } prog_wr_t;

    typedef struct packed {
        logic        valid;
        logic [21:0] addr;
        slot_id_e    tag;
    } sdram_rd_t;

    // Scroll reads the half word, object and main pick one byte
    typedef union packed {
        logic [15:0]     half;
        logic [1:0][7:0] bytes;  // Byte 0 is the low byte
    } rom_word_u;

    typedef struct packed {
        logic      valid;
        rom_word_u data;
    } sdram_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [21:0] addr;  // Word address inside the slot region
    } slot_req_t;

endpackage

// ==== kicker_frac_cen.sv ====
`timescale 1ns/1ps
`include "kicker_defines.svh"

module kicker_frac_cen (
    input  logic clk,
    input  logic arst_n,
    output logic pxl2_cen,
    output logic pxl_cen,
    output logic snd_cen
);

    localparam logic [7:0] STEP = 8'(`CEN_N);
    localparam logic [7:0] WRAP = 8'(`CEN_M);

    logic [7:0] acc;
    logic [7:0] sum;
    logic       base;
    logic [1:0] div;  // Counts base pulses for the slower enables

    assign sum  = acc + STEP;
    assign base = sum >= WRAP;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc      <= '0;
            div      <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
            snd_cen  <= 1'b0;
        end else begin
            acc      <= base ? sum - WRAP : sum;
            pxl2_cen <= base;
            pxl_cen  <= base && !div[0];      // Every second base pulse
            snd_cen  <= base && div == 2'd0;  // Every fourth
            if (base) begin
                div <= div + 2'd1;
            end
        end
    end

    a_pxl_in_pxl2: assert property (@(posedge clk) disable iff (!arst_n)
        pxl_cen |-> pxl2_cen);

endmodule

// ==== kicker_dwnld.sv ====
`timescale 1ns/1ps
`include "kicker_defines.svh"

module kicker_dwnld (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 downloading,
    input  logic [24:0]          ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic                 ioctl_wr,
    output kicker_pkg::prog_wr_t prog,
    output logic                 prog_we,
    output logic                 prom_we
);

    logic        wr_en;
    logic        in_prom;
    logic        in_scr;
    logic [21:0] word_addr;
    logic [21:0] swz_addr;

    assign wr_en     = ioctl_wr && downloading;
    assign in_prom   = ioctl_addr >= `PROM_START;
    assign in_scr    = ioctl_addr > `SCR_START && ioctl_addr < `OBJ_START;
    assign word_addr = ioctl_addr[22:1];  // 8 MB SDRAM

    // Scroll tiles are stored with the row bits rotated
    always_comb begin
        swz_addr = word_addr;
        if (in_scr) begin
            swz_addr[0]   = word_addr[3];
            swz_addr[3:1] = word_addr[2:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prog_we <= wr_en && !in_prom;
            prom_we <= wr_en && in_prom;
        end
    end

    // PROM writes reuse the same payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog.addr <= swz_addr;
            prog.data <= ioctl_dout;
            prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;  // Odd byte is the high lane
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(prog_we && prom_we));

endmodule

// ==== kicker_rom_slot.sv ====
`timescale 1ns/1ps

module kicker_rom_slot #(
    parameter int DW = 8
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         cs,
    input  logic [(DW == 8 ? 22 : 21):0] addr,
    input  logic                         grant,
    input  logic                         rsp_valid,
    input  kicker_pkg::rom_word_u        rsp_data,
    output kicker_pkg::slot_req_t        req,
    output logic [DW-1:0]                data,
    output logic                         ok
);

    logic [21:0]           word_addr;
    logic [21:0]           cache_addr;
    kicker_pkg::rom_word_u cache_data;
    logic                  cache_vld;
    logic [21:0]           pend_addr;  // Address of the read in progress
    logic                  req_vld;
    logic                  waiting;    // Granted, response not back yet
    logic                  hit;
    logic                  fill_hit;
    logic                  start;

    generate
        if (DW == 8) begin : g_byte
            assign word_addr = addr[22:1];
            assign data      = cache_data.bytes[addr[0]];
        end else begin : g_half
            assign word_addr = addr;
            assign data      = cache_data.half;
        end
    endgenerate

    assign hit      = cache_vld && cache_addr == word_addr;
    assign fill_hit = rsp_valid && pend_addr == word_addr;
    assign start    = cs && !hit && !req_vld && !waiting;

    assign req.valid = req_vld;
    assign req.addr  = pend_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_vld   <= 1'b0;
            waiting   <= 1'b0;
            cache_vld <= 1'b0;
            ok        <= 1'b0;
        end else begin
            ok <= cs && (hit || fill_hit);
            if (req_vld && grant) begin
                req_vld <= 1'b0;
                waiting <= 1'b1;
            end else if (start) begin
                req_vld <= 1'b1;
            end
            if (rsp_valid) begin
                waiting   <= 1'b0;
                cache_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pend_addr <= word_addr;
        end
        if (rsp_valid) begin
            cache_addr <= pend_addr;
            cache_data <= rsp_data;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        req_vld && !grant |=> req_vld && $stable(pend_addr));

    // Arbiter only routes a response back to a slot that was granted
    a_rsp_expected: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> waiting);

endmodule

// ==== kicker_rom_arb.sv ====
`timescale 1ns/1ps
`include "kicker_defines.svh"

module kicker_rom_arb (
    input  logic                   clk,
    input  logic                   arst_n,
    input  kicker_pkg::slot_req_t  scr_req,
    input  kicker_pkg::slot_req_t  obj_req,
    input  kicker_pkg::slot_req_t  main_req,
    input  logic                   sdram_credit,
    input  kicker_pkg::sdram_rsp_t sdram_rsp,
    output logic                   scr_grant,
    output logic                   obj_grant,
    output logic                   main_grant,
    output kicker_pkg::sdram_rd_t  sdram_req,
    output logic                   scr_rsp_valid,
    output logic                   obj_rsp_valid,
    output logic                   main_rsp_valid,
    output kicker_pkg::rom_word_u  rsp_data
);

    localparam int QD = `SDRAM_CREDITS;
    localparam int CW = $clog2(QD + 1);
    localparam int PW = (QD > 1) ? $clog2(QD) : 1;

    localparam logic [21:0] SCR_OFS = 22'(`SCR_START >> 1);
    localparam logic [21:0] OBJ_OFS = 22'(`OBJ_START >> 1);

    logic [CW-1:0]        credits;
    logic                 issue;
    logic                 pop;
    kicker_pkg::slot_id_e pick;
    logic [21:0]          pick_addr;

    kicker_pkg::slot_id_e tag_q [QD];  // Tags of reads in flight, oldest at rd_ptr
    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        rd_ptr;
    logic [CW-1:0]        q_cnt;
    kicker_pkg::slot_id_e head;

    logic                 req_vld;
    logic [21:0]          req_addr;
    kicker_pkg::slot_id_e req_tag;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(QD - 1)) ? '0 : p + 1'b1;
    endfunction

    // Scroll first, then object, main CPU last
    always_comb begin
        pick      = kicker_pkg::SLOT_MAIN;
        pick_addr = main_req.addr;  // Main ROM starts at zero
        if (scr_req.valid) begin
            pick      = kicker_pkg::SLOT_SCR;
            pick_addr = scr_req.addr + SCR_OFS;
        end else if (obj_req.valid) begin
            pick      = kicker_pkg::SLOT_OBJ;
            pick_addr = obj_req.addr + OBJ_OFS;
        end
    end

    assign issue = credits != '0 && (scr_req.valid || obj_req.valid || main_req.valid);
    assign pop   = sdram_rsp.valid;

    assign scr_grant  = issue && pick == kicker_pkg::SLOT_SCR;
    assign obj_grant  = issue && pick == kicker_pkg::SLOT_OBJ;
    assign main_grant = issue && pick == kicker_pkg::SLOT_MAIN;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CW'(QD);
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_cnt   <= '0;
            req_vld <= 1'b0;
        end else begin
            credits <= credits - CW'(issue) + CW'(sdram_credit);
            q_cnt   <= q_cnt + CW'(issue) - CW'(pop);
            req_vld <= issue;
            if (issue) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tag_q[wr_ptr] <= pick;
            req_addr      <= pick_addr;
            req_tag       <= pick;
        end
    end

    assign sdram_req.valid = req_vld;
    assign sdram_req.addr  = req_addr;
    assign sdram_req.tag   = req_tag;

    // Responses come back in issue order
    assign head           = tag_q[rd_ptr];
    assign scr_rsp_valid  = pop && head == kicker_pkg::SLOT_SCR;
    assign obj_rsp_valid  = pop && head == kicker_pkg::SLOT_OBJ;
    assign main_rsp_valid = pop && head == kicker_pkg::SLOT_MAIN;
    assign rsp_data       = sdram_rsp.data;

    a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= CW'(QD));

    a_rsp_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_rsp.valid |-> q_cnt != '0);

endmodule

// ==== kicker_game.sv ====
`timescale 1ns/1ps

module kicker_game (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   downloading,
    input  logic [24:0]            ioctl_addr,
    input  logic [7:0]             ioctl_dout,
    input  logic                   ioctl_wr,
    input  logic                   scr_cs,
    input  logic [21:0]            scr_addr,   // Word address
    input  logic                   obj_cs,
    input  logic [22:0]            obj_addr,   // Byte address
    input  logic                   main_cs,
    input  logic [22:0]            main_addr,  // Byte address
    input  logic                   sdram_credit,
    input  kicker_pkg::sdram_rsp_t sdram_rsp,
    output kicker_pkg::prog_wr_t   prog,
    output logic                   prog_we,
    output logic                   prom_we,
    output kicker_pkg::sdram_rd_t  sdram_req,
    output logic [15:0]            scr_data,
    output logic                   scr_ok,
    output logic [7:0]             obj_data,
    output logic                   obj_ok,
    output logic [7:0]             main_data,
    output logic                   main_ok,
    output logic                   pxl_cen,
    output logic                   pxl2_cen,
    output logic                   snd_cen
);

    kicker_pkg::slot_req_t scr_req;
    kicker_pkg::slot_req_t obj_req;
    kicker_pkg::slot_req_t main_req;
    logic                  scr_grant;
    logic                  obj_grant;
    logic                  main_grant;
    logic                  scr_rsp_valid;
    logic                  obj_rsp_valid;
    logic                  main_rsp_valid;
    kicker_pkg::rom_word_u rsp_data;

    kicker_frac_cen u_cen (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .snd_cen  ( snd_cen  )
    );

    kicker_dwnld u_dwnld (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog        ( prog        ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    kicker_rom_slot #(.DW(16)) u_scr (
        .clk       ( clk           ),
        .arst_n    ( arst_n        ),
        .cs        ( scr_cs        ),
        .addr      ( scr_addr      ),
        .grant     ( scr_grant     ),
        .rsp_valid ( scr_rsp_valid ),
        .rsp_data  ( rsp_data      ),
        .req       ( scr_req       ),
        .data      ( scr_data      ),
        .ok        ( scr_ok        )
    );

    kicker_rom_slot #(.DW(8)) u_obj (
        .clk       ( clk           ),
        .arst_n    ( arst_n        ),
        .cs        ( obj_cs        ),
        .addr      ( obj_addr      ),
        .grant     ( obj_grant     ),
        .rsp_valid ( obj_rsp_valid ),
        .rsp_data  ( rsp_data      ),
        .req       ( obj_req       ),
        .data      ( obj_data      ),
        .ok        ( obj_ok        )
    );

    kicker_rom_slot #(.DW(8)) u_main (
        .clk       ( clk            ),
        .arst_n    ( arst_n         ),
        .cs        ( main_cs        ),
        .addr      ( main_addr      ),
        .grant     ( main_grant     ),
        .rsp_valid ( main_rsp_valid ),
        .rsp_data  ( rsp_data       ),
        .req       ( main_req       ),
        .data      ( main_data      ),
        .ok        ( main_ok        )
    );

    kicker_rom_arb u_arb (
        .clk            ( clk            ),
        .arst_n         ( arst_n         ),
        .scr_req        ( scr_req        ),
        .obj_req        ( obj_req        ),
        .main_req       ( main_req       ),
        .sdram_credit   ( sdram_credit   ),
        .sdram_rsp      ( sdram_rsp      ),
        .scr_grant      ( scr_grant      ),
        .obj_grant      ( obj_grant      ),
        .main_grant     ( main_grant     ),
        .sdram_req      ( sdram_req      ),
        .scr_rsp_valid  ( scr_rsp_valid  ),
        .obj_rsp_valid  ( obj_rsp_valid  ),
        .main_rsp_valid ( main_rsp_valid ),
        .rsp_data       ( rsp_data       )
    );

endmodule

// ==== tb_sdram_model.sv ====
`timescale 1ns/1ps

module tb_sdram_model (
    input  logic                   clk,
    input  logic                   arst_n,
    input  kicker_pkg::prog_wr_t   prog,
    input  logic                   prog_we,
    input  kicker_pkg::sdram_rd_t  sdram_req,
    input  logic                   hold_credits,  // Starves the arbiter while high
    output kicker_pkg::sdram_rsp_t sdram_rsp,
    output logic                   sdram_credit
);

    logic [15:0] mem [0:127];
    logic [31:0] seed;
    int          cyc;
    int          last_due;
    int          rd_due [$];
    logic [21:0] rd_addr [$];
    int          cr_due [$];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        for (int i = 0; i < 128; i++) begin
            mem[i] = 16'h0000;
        end
        seed         = 32'hd600;
        cyc          = 0;
        last_due     = 0;
        sdram_rsp    = '0;
        sdram_credit = 1'b0;
    end

    always @(posedge clk) begin
        if (prog_we) begin
            if (!prog.mask[0]) mem[prog.addr[6:0]][7:0]  <= prog.data;
            if (!prog.mask[1]) mem[prog.addr[6:0]][15:8] <= prog.data;
        end
    end

    // Outputs change on the falling edge only
    always @(negedge clk) begin
        int due;
        cyc          = cyc + 1;
        sdram_rsp    = '0;
        sdram_credit = 1'b0;
        if (!arst_n) begin
            rd_due.delete();
            rd_addr.delete();
            cr_due.delete();
            last_due = cyc;
        end else begin
            if (sdram_req.valid) begin
                seed = lcg_next(seed);
                due  = cyc + 2 + int'(seed[18:16]);  // 2 to 9 cycles
                if (due <= last_due) due = last_due + 1;  // Keep answers in order
                last_due = due;
                rd_due.push_back(due);
                rd_addr.push_back(sdram_req.addr);
            end
            if (rd_due.size() > 0 && rd_due[0] <= cyc) begin
                void'(rd_due.pop_front());
                sdram_rsp.valid     = 1'b1;
                sdram_rsp.data.half = mem[7'(rd_addr.pop_front())];
                seed = lcg_next(seed);
                cr_due.push_back(cyc + int'(seed[20:16]) % 6);
            end
            if (!hold_credits && cr_due.size() > 0 && cr_due[0] <= cyc) begin
                void'(cr_due.pop_front());
                sdram_credit = 1'b1;
            end
        end
    end

endmodule

// ==== tb_kicker.sv ====
`timescale 1ns/1ps
`include "kicker_defines.svh"

module tb_kicker;

    localparam int RD_TIMEOUT = 200;
    localparam int N_READS    = 16;
    localparam int N_WAITS    = 4 * N_READS + 1;
    localparam int WD_CYCLES  = 10 + 1260 + 256 * 2 + 70 + N_WAITS * (RD_TIMEOUT + 1) + 200;

    logic                   clk;
    logic                   arst_n;
    logic                   downloading;
    logic [24:0]            ioctl_addr;
    logic [7:0]             ioctl_dout;
    logic                   ioctl_wr;
    logic                   scr_cs;
    logic [21:0]            scr_addr;
    logic                   obj_cs;
    logic [22:0]            obj_addr;
    logic                   main_cs;
    logic [22:0]            main_addr;
    logic                   sdram_credit;
    logic                   hold_credits;
    kicker_pkg::sdram_rsp_t sdram_rsp;
    kicker_pkg::prog_wr_t   prog;
    logic                   prog_we;
    logic                   prom_we;
    kicker_pkg::sdram_rd_t  sdram_req;
    logic [15:0]            scr_data;
    logic [7:0]             obj_data;
    logic [7:0]             main_data;
    logic                   scr_ok;
    logic                   obj_ok;
    logic                   main_ok;
    logic                   pxl_cen;
    logic                   pxl2_cen;
    logic                   snd_cen;

    logic [7:0]           dl_byte [0:255];  // Loader image
    logic [15:0]          exp_word [0:127]; // SDRAM contents after the swizzle
    logic [31:0]          rnd;
    int                   err_cnt;
    int                   err_mark;
    int                   test_cnt;
    logic                 idle_chk;
    logic                 cen_win;
    logic                 cen_chk;
    int                   pxl2_cnt;
    int                   pxl_cnt;
    int                   snd_cnt;
    logic                 dl_chk;
    logic                 dl_prom_q;
    kicker_pkg::prog_wr_t dl_exp_q;
    int                   outst;
    logic [7:0]           main_exp;
    logic [7:0]           obj_exp;
    logic [15:0]          scr_exp;
    kicker_pkg::slot_id_e tag_exp;

    assign main_exp = dl_byte[{2'b00, main_addr[5:0]}];
    assign obj_exp  = dl_byte[{2'b10, obj_addr[5:0]}];
    assign scr_exp  = exp_word[{2'b01, scr_addr[4:0]}];

    // Slot that owns the SDRAM word being read
    assign tag_exp = (sdram_req.addr >= 22'(`OBJ_START >> 1)) ? kicker_pkg::SLOT_OBJ :
                     (sdram_req.addr >= 22'(`SCR_START >> 1)) ? kicker_pkg::SLOT_SCR :
                     kicker_pkg::SLOT_MAIN;

    kicker_game dut0 (.*);

    tb_sdram_model u_mem (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Programming write the loader byte should produce
    function automatic kicker_pkg::prog_wr_t prog_expect(input logic [24:0] a,
                                                         input logic [7:0] d);
        kicker_pkg::prog_wr_t p;
        logic [21:0]          w;
        w = a[22:1];
        if (a > `SCR_START && a < `OBJ_START) w = {w[21:4], w[2:0], w[3]};
        p.addr = w;
        p.data = d;
        p.mask = 2'b11;
        p.mask[a[0]] = 1'b0;
        return p;
    endfunction

    always @(posedge clk) begin
        if (cen_win) begin
            pxl2_cnt <= pxl2_cnt + int'(pxl2_cen);
            pxl_cnt  <= pxl_cnt + int'(pxl_cen);
            snd_cnt  <= snd_cnt + int'(snd_cen);
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dl_chk <= 1'b0;
            outst  <= 0;
        end else begin
            dl_chk    <= ioctl_wr && downloading;
            dl_prom_q <= ioctl_addr >= `PROM_START;
            dl_exp_q  <= prog_expect(ioctl_addr, ioctl_dout);
            outst     <= outst + int'(sdram_req.valid) - int'(sdram_credit);
        end
    end

    a_idle: assert property (@(posedge clk) idle_chk |->
        {prog_we, prom_we, sdram_req.valid, scr_ok, obj_ok, main_ok,
         pxl_cen, pxl2_cen, snd_cen} == 9'b0)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR reset_idle expected 000000000 actual %b",
                {$sampled(prog_we), $sampled(prom_we), $sampled(sdram_req.valid),
                 $sampled(scr_ok), $sampled(obj_ok), $sampled(main_ok),
                 $sampled(pxl_cen), $sampled(pxl2_cen), $sampled(snd_cen)});
        end

    a_cen_pxl2: assert property (@(posedge clk) cen_chk |-> pxl2_cnt == 160)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR cen_count expected 160 actual %0d", $sampled(pxl2_cnt));
        end
    a_cen_pxl: assert property (@(posedge clk) cen_chk |-> pxl_cnt == 80)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR cen_count expected 80 actual %0d", $sampled(pxl_cnt));
        end
    a_cen_snd: assert property (@(posedge clk) cen_chk |-> snd_cnt == 40)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR cen_count expected 40 actual %0d", $sampled(snd_cnt));
        end

    // One strobe per loader write, one cycle later
    a_dl_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        {prog_we, prom_we} == (dl_chk ? (dl_prom_q ? 2'b01 : 2'b10) : 2'b00))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR download_strobe expected %b actual %b",
                $sampled(dl_chk) ? ($sampled(dl_prom_q) ? 2'b01 : 2'b10) : 2'b00,
                {$sampled(prog_we), $sampled(prom_we)});
        end

    a_dl_word: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |-> prog == dl_exp_q)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR download_word expected %h actual %h",
                $sampled(dl_exp_q), $sampled(prog));
        end

    a_main_rd: assert property (@(posedge clk) disable iff (!arst_n)
        main_ok && $stable(main_addr) |-> main_data == main_exp)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR main_read expected %h actual %h",
                $sampled(main_exp), $sampled(main_data));
        end

    a_obj_rd: assert property (@(posedge clk) disable iff (!arst_n)
        obj_ok && $stable(obj_addr) |-> obj_data == obj_exp)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR obj_read expected %h actual %h",
                $sampled(obj_exp), $sampled(obj_data));
        end

    a_scr_rd: assert property (@(posedge clk) disable iff (!arst_n)
        scr_ok && $stable(scr_addr) |-> scr_data == scr_exp)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR scr_read expected %h actual %h",
                $sampled(scr_exp), $sampled(scr_data));
        end

    a_req_tag: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req.valid |-> sdram_req.tag == tag_exp)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR read_tag expected %0d actual %0d",
                $sampled(tag_exp), $sampled(sdram_req.tag));
        end

    a_outstanding: assert property (@(posedge clk) disable iff (!arst_n) outst <= 2)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR credit_starve expected <=2 actual %0d", $sampled(outst));
        end

    task automatic end_test(input string name);
        test_cnt = test_cnt + 1;
        $display("test %s finished with %0d errors", name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    // Polls on the falling edge, where ok is settled
    task automatic wait_ok(input int sel, input string name);
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < RD_TIMEOUT) begin
            @(negedge clk);
            seen = (sel == 0) ? scr_ok : (sel == 1) ? obj_ok :
                   (sel == 2) ? main_ok : (scr_ok && obj_ok && main_ok);
            n++;
        end
        if (!seen) begin
            err_cnt = err_cnt + 1;
            $display("%s: ok never rose within %0d cycles", name, RD_TIMEOUT);
        end
        @(negedge clk);  // Address held one more cycle so the read checks sample it
    endtask

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        kicker_pkg::prog_wr_t p;
        clk          = 1'b0;
        arst_n       = 1'b1;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_dout   = '0;
        ioctl_wr     = 1'b0;
        scr_cs       = 1'b0;
        scr_addr     = '0;
        obj_cs       = 1'b0;
        obj_addr     = '0;
        main_cs      = 1'b0;
        main_addr    = '0;
        hold_credits = 1'b0;
        idle_chk     = 1'b0;
        cen_win      = 1'b0;
        cen_chk      = 1'b0;
        pxl2_cnt     = 0;
        pxl_cnt      = 0;
        snd_cnt      = 0;
        err_cnt      = 0;
        err_mark     = 0;
        test_cnt     = 0;
        rnd          = 32'hd600;
        for (int i = 0; i < 128; i++) exp_word[i] = 16'h0000;
        for (int b = 0; b < 256; b++) begin
            rnd = lcg_next(rnd);
            dl_byte[b] = rnd[23:16] ^ 8'(b);
        end
        // Scroll words as the loader rule lays them out
        for (int b = 'h40; b < 'h80; b++) begin
            p = prog_expect(25'(b), dl_byte[b]);
            if (!p.mask[0]) exp_word[p.addr[6:0]][7:0] = p.data;
            else exp_word[p.addr[6:0]][15:8] = p.data;
        end
        #1 arst_n = 1'b0;
        repeat (10) @(negedge clk);
        arst_n   = 1'b1;
        idle_chk = 1'b1;
        @(negedge clk);
        idle_chk = 1'b0;
        cen_win  = 1'b1;
        repeat (1250) @(negedge clk);
        cen_win = 1'b0;
        cen_chk = 1'b1;
        @(negedge clk);
        cen_chk = 1'b0;
        end_test("reset_cen");

        downloading = 1'b1;
        for (int b = 0; b < 256; b++) begin
            @(negedge clk);
            ioctl_addr = 25'(b);
            ioctl_dout = dl_byte[b];
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
        end
        repeat (3) @(negedge clk);
        downloading = 1'b0;
        end_test("download");

        main_cs = 1'b1;
        obj_cs  = 1'b1;
        for (int i = 0; i < N_READS; i++) begin
            rnd = lcg_next(rnd);
            main_addr = 23'(rnd[21:16]);
            wait_ok(2, "main_read");
            obj_addr = 23'(rnd[29:24]);
            wait_ok(1, "obj_read");
            main_addr = main_addr ^ 23'd1;  // Same word so the cache hits
            wait_ok(2, "main_read");
        end
        end_test("main_obj_read");

        scr_cs = 1'b1;
        for (int i = 0; i < N_READS; i++) begin
            rnd = lcg_next(rnd);
            scr_addr = 22'(rnd[20:16]);
            wait_ok(0, "scr_read");
        end
        end_test("scroll_read");

        repeat (20) @(negedge clk);
        hold_credits = 1'b1;
        scr_addr  = scr_addr ^ 22'd1;  // New words in every slot
        obj_addr  = obj_addr ^ 23'd2;
        main_addr = main_addr ^ 23'd2;
        repeat (40) @(negedge clk);
        hold_credits = 1'b0;
        wait_ok(3, "credit_starve");
        scr_cs  = 1'b0;
        obj_cs  = 1'b0;
        main_cs = 1'b0;
        repeat (5) @(negedge clk);
        end_test("credit_starve");

        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
kicker_pkg.sv
kicker_frac_cen.sv
kicker_dwnld.sv
kicker_rom_slot.sv
kicker_rom_arb.sv
kicker_game.sv
tb_sdram_model.sv
tb_kicker.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_kicker -f flist.f -o sim_kicker
	./obj_dir/sim_kicker | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
